// ==== rtl/eeprom_pkg.sv ====
package eeprom_pkg;

    // 24C16 device type code, upper nibble of the control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    localparam int ADDR_W  = 11;   // 2K bytes
    localparam int BLOCK_W = 3;    // 256-byte blocks, carried in the control byte

    // commands the sequencer hands to the bit engine
    typedef enum logic [1:0] {
        CMD_START,   // start or repeated start, one scl period
        CMD_WRITE,   // 8 bits out, slave ack in
        CMD_READ,    // 8 bits in, master ack/nack out
        CMD_STOP     // stop, releases the bus
    } bit_cmd_t;

endpackage

// ==== rtl/i2c_bit_if.sv ====
`timescale 1ns/1ps

interface i2c_bit_if;

    eeprom_pkg::bit_cmd_t cmd;
    logic                 cmd_valid;   // one cycle, only while engine idle
    logic [7:0]           tx_byte;
    logic                 tx_nack;     // ack bit sent after a read
    logic [7:0]           rx_byte;
    logic                 rx_ack;      // high when slave pulled sda low
    logic                 done;        // one pulse per command

    modport master (
        output cmd,
        output cmd_valid,
        output tx_byte,
        output tx_nack,
        input  rx_byte,
        input  rx_ack,
        input  done
    );

    modport engine (
        input  cmd,
        input  cmd_valid,
        input  tx_byte,
        input  tx_nack,
        output rx_byte,
        output rx_ack,
        output done
    );

endinterface

// ==== rtl/i2c_bit_engine.sv ====
`timescale 1ns/1ps

module i2c_bit_engine #(
    parameter int CLK_DIV = 2
) (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      sda_in,
    output logic      scl,
    output logic      sda_out,
    output logic      sda_oe,
    i2c_bit_if.engine bus
);

    localparam int QW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    eeprom_pkg::bit_cmd_t cur_cmd;
    logic                 active;
    logic [QW-1:0]        q_cnt;
    logic [1:0]           phase;
    logic [3:0]           bit_cnt;
    logic [7:0]           sh_reg;
    logic                 nack_r;
    logic                 q_last;
    logic                 ack_slot;
    logic                 last_bit;

    assign q_last   = (q_cnt == QW'(CLK_DIV - 1));
    assign ack_slot = (bit_cnt == 4'd8);   // ninth bit of a byte

    // start and stop are a single scl period
    assign last_bit = ack_slot
                      || (cur_cmd == eeprom_pkg::CMD_START)
                      || (cur_cmd == eeprom_pkg::CMD_STOP);

    assign bus.rx_byte = sh_reg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active     <= 1'b0;
            cur_cmd    <= eeprom_pkg::CMD_STOP;   // idle looks like the tail of a stop
            q_cnt      <= '0;
            phase      <= 2'd3;
            bit_cnt    <= '0;
            bus.done   <= 1'b0;
            bus.rx_ack <= 1'b0;
        end
        else
        begin
            bus.done <= 1'b0;
            if (!active)
            begin
                if (bus.cmd_valid)
                begin
                    active  <= 1'b1;
                    cur_cmd <= bus.cmd;
                    q_cnt   <= '0;
                    phase   <= 2'd0;
                    bit_cnt <= '0;
                end
            end
            else if (q_last)
            begin
                q_cnt <= '0;
                phase <= phase + 2'd1;   // wraps 3 -> 0
                if (phase == 2'd2 && ack_slot && cur_cmd == eeprom_pkg::CMD_WRITE)
                    bus.rx_ack <= ~sda_in;   // slave acks by pulling low
                if (phase == 2'd3)
                begin
                    if (last_bit)
                    begin
                        active   <= 1'b0;
                        phase    <= 2'd3;   // hold outputs of the last quarter
                        bus.done <= 1'b1;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
            end
            else
            begin
                q_cnt <= q_cnt + QW'(1);
            end
        end
    end

    // shift register, msb first
    always_ff @(posedge CLK)
    begin
        if (!active && bus.cmd_valid)
        begin
            sh_reg <= bus.tx_byte;
            nack_r <= bus.tx_nack;
        end
        else if (active && q_last && !ack_slot)
        begin
            if (phase == 2'd2 && cur_cmd == eeprom_pkg::CMD_READ)
                sh_reg <= {sh_reg[6:0], sda_in};   // middle of scl high
            else if (phase == 2'd3 && cur_cmd == eeprom_pkg::CMD_WRITE)
                sh_reg <= {sh_reg[6:0], 1'b0};     // next bit goes out while scl low
        end
    end

    // scl low, high, high, low per bit; sda moves only at quarter 0
    always_comb
    begin
        scl     = (phase == 2'd1) || (phase == 2'd2);
        sda_oe  = 1'b1;
        sda_out = 1'b1;
        case (cur_cmd)
            eeprom_pkg::CMD_START:
            begin
                sda_out = (phase < 2'd2);   // falls with scl high
            end
            eeprom_pkg::CMD_STOP:
            begin
                scl     = (phase != 2'd0);
                sda_out = (phase >= 2'd2);   // rises with scl high
                sda_oe  = (phase != 2'd3);   // let go once the line is high
            end
            eeprom_pkg::CMD_WRITE:
            begin
                if (ack_slot)
                    sda_oe = 1'b0;   // slave drives the ack
                else
                    sda_out = sh_reg[7];
            end
            default:
            begin
                if (ack_slot)
                    sda_out = nack_r;
                else
                    sda_oe = 1'b0;   // slave drives data
            end
        endcase
    end

endmodule

// ==== rtl/eeprom_sequencer.sv ====
`timescale 1ns/1ps

module eeprom_sequencer (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wr_data,
    output logic [7:0]                    rd_data,
    output logic                          ack,
    output logic                          nack_err,
    output logic                          busy,
    i2c_bit_if.master                     bus
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA_W,
        S_RSTART,
        S_CTRL_R,
        S_DATA_R,
        S_STOP
    } seq_state_t;

    seq_state_t                    state;
    seq_state_t                    next_state;
    logic                          issued;       // command of this phase already sent
    logic                          op_rd;
    logic [eeprom_pkg::ADDR_W-1:0] addr_r;
    logic [7:0]                    data_r;
    logic [7:0]                    rd_buf;
    logic                          err_r;
    logic                          written_nack;
    logic [eeprom_pkg::BLOCK_W-1:0] block;

    assign block         = addr_r[eeprom_pkg::ADDR_W-1 -: eeprom_pkg::BLOCK_W];
    assign busy          = (state != S_IDLE);
    assign bus.cmd_valid = (state != S_IDLE) && !issued;

    // command and byte for the current phase
    always_comb
    begin
        bus.cmd     = eeprom_pkg::CMD_WRITE;
        bus.tx_byte = {eeprom_pkg::DEVICE_CODE, block, 1'b0};
        bus.tx_nack = 1'b0;
        case (state)
            S_START, S_RSTART:
                bus.cmd = eeprom_pkg::CMD_START;
            S_ADDR:
                bus.tx_byte = addr_r[7:0];
            S_DATA_W:
                bus.tx_byte = data_r;
            S_CTRL_R:
                bus.tx_byte = {eeprom_pkg::DEVICE_CODE, block, 1'b1};
            S_DATA_R:
            begin
                bus.cmd     = eeprom_pkg::CMD_READ;
                bus.tx_nack = 1'b1;   // single byte read ends with nack
            end
            S_STOP:
                bus.cmd = eeprom_pkg::CMD_STOP;
            default:
                bus.cmd = eeprom_pkg::CMD_WRITE;
        endcase
    end

    always_comb
    begin
        written_nack = !bus.rx_ack
                       && (state == S_CTRL_W || state == S_ADDR
                           || state == S_DATA_W || state == S_CTRL_R);
        case (state)
            S_START:  next_state = S_CTRL_W;
            S_CTRL_W: next_state = S_ADDR;
            S_ADDR:   next_state = op_rd ? S_RSTART : S_DATA_W;
            S_RSTART: next_state = S_CTRL_R;
            S_CTRL_R: next_state = S_DATA_R;
            S_DATA_W: next_state = S_STOP;
            S_DATA_R: next_state = S_STOP;
            default:  next_state = S_IDLE;
        endcase
        if (written_nack)
            next_state = S_STOP;   // abort, straight to stop
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= S_IDLE;
            issued   <= 1'b0;
            ack      <= 1'b0;
            nack_err <= 1'b0;
            err_r    <= 1'b0;
            rd_data  <= '0;
        end
        else
        begin
            ack <= 1'b0;
            if (bus.cmd_valid)
                issued <= 1'b1;
            if (state == S_IDLE)
            begin
                if (wr || rd)
                begin
                    err_r <= 1'b0;
                    state <= S_START;
                end
            end
            else if (bus.done)
            begin
                issued <= 1'b0;
                state  <= next_state;
                if (written_nack)
                    err_r <= 1'b1;
                if (state == S_STOP)
                begin
                    ack      <= 1'b1;
                    nack_err <= err_r;
                    if (op_rd && !err_r)
                        rd_data <= rd_buf;
                end
            end
        end
    end

    // transaction payload
    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && (wr || rd))
        begin
            op_rd  <= !wr;   // wr wins
            addr_r <= addr;
            data_r <= wr_data;
        end
        if (state == S_DATA_R && bus.done)
            rd_buf <= bus.rx_byte;
    end

endmodule

// ==== rtl/eeprom_ctrl_top.sv ====
`timescale 1ns/1ps

module eeprom_ctrl_top #(
    parameter int CLK_DIV = 2   // CLK cycles per quarter scl period
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wr_data,
    input  logic                          sda_in,
    output logic [7:0]                    rd_data,
    output logic                          ack,
    output logic                          nack_err,
    output logic                          busy,
    output logic                          scl,
    output logic                          sda_out,
    output logic                          sda_oe
);

    i2c_bit_if bit_bus ();

    eeprom_sequencer u_seq (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .ack      (ack),
        .nack_err (nack_err),
        .busy     (busy),
        .bus      (bit_bus.master)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_engine (
        .CLK     (CLK),
        .RESET   (RESET),
        .sda_in  (sda_in),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe),
        .bus     (bit_bus.engine)
    );

endmodule

// ==== test/i2c_eeprom_model.sv ====
`timescale 1ns/1ps

module i2c_eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,          // resolved line
    input  logic force_nack,
    output logic sda_low        // open-drain pull down
);

    localparam logic [1:0] M_IDLE = 2'd0;
    localparam logic [1:0] M_RX   = 2'd1;
    localparam logic [1:0] M_TX   = 2'd2;

    logic [7:0]  mem [0:2047];
    logic [1:0]  mode;
    logic [3:0]  cnt;
    logic [1:0]  byte_idx;
    logic [7:0]  shreg;
    logic [7:0]  txreg;
    logic [2:0]  block;
    logic [10:0] ptr;
    logic        rd_mode;
    logic        nacked;
    logic        scl_q;
    logic        sda_q;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;   // erased
    end

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
        begin
            mode    <= M_IDLE;
            sda_low <= 1'b0;
            cnt     <= '0;
        end
        else if (scl && scl_q && sda_q && !sda)
        begin
            mode     <= M_RX;   // start or repeated start
            cnt      <= '0;
            byte_idx <= '0;
            nacked   <= 1'b0;
            sda_low  <= 1'b0;
        end
        else if (scl && scl_q && !sda_q && sda)
        begin
            mode    <= M_IDLE;  // stop
            sda_low <= 1'b0;
        end
        else if (scl && !scl_q && mode == M_RX && cnt < 4'd8)
        begin
            shreg <= {shreg[6:0], sda};
            cnt   <= cnt + 4'd1;
        end
        else if (!scl && scl_q)
        begin
            if (mode == M_RX && cnt == 4'd8)
            begin
                cnt <= 4'd9;
                if (force_nack || (byte_idx == 2'd0 && shreg[7:4] != 4'b1010))
                begin
                    nacked <= 1'b1;
                end
                else
                begin
                    sda_low <= 1'b1;
                    if (byte_idx == 2'd0)
                    begin
                        block   <= shreg[3:1];
                        rd_mode <= shreg[0];
                    end
                    else if (byte_idx == 2'd1)
                        ptr <= {block, shreg};
                    else
                        mem[ptr] <= shreg;
                    if (byte_idx != 2'd3)
                        byte_idx <= byte_idx + 2'd1;
                end
            end
            else if (mode == M_RX && cnt == 4'd9)
            begin
                sda_low <= 1'b0;
                cnt     <= '0;
                if (nacked)
                    mode <= M_IDLE;
                else if (rd_mode)
                begin
                    mode    <= M_TX;
                    txreg   <= mem[ptr];
                    sda_low <= !mem[ptr][7];
                    cnt     <= 4'd1;
                end
            end
            else if (mode == M_TX)
            begin
                if (cnt < 4'd8)
                begin
                    sda_low <= !txreg[3'(4'd7 - cnt)];
                    cnt     <= cnt + 4'd1;
                end
                else if (cnt == 4'd8)
                begin
                    sda_low <= 1'b0;   // master acks now
                    cnt     <= 4'd9;
                end
                else
                    mode <= M_IDLE;
            end
        end
    end

endmodule

// ==== test/eeprom_ctrl_checker.sv ====
`timescale 1ns/1ps

module eeprom_ctrl_checker (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       ack,
    input  logic       nack_err,
    input  logic [7:0] rd_data,
    input  logic       check_rd,      // current transaction is a read
    input  logic [7:0] exp_rd_data,
    input  logic       exp_nack,
    output int         errors,
    output int         acks
);

    // outputs are registered, so the falling edge sees them settled
    always @(negedge CLK)
    begin
        if (RESET)
        begin
            errors = 0;
            acks   = 0;
        end
        else if (ack)
        begin
            acks = acks + 1;
            if (nack_err !== exp_nack)
            begin
                $display("ERROR nack_err: got %h expected %h", nack_err, exp_nack);
                errors = errors + 1;
            end
            if (check_rd && !exp_nack && rd_data !== exp_rd_data)
            begin
                $display("ERROR rd_data: got %h expected %h", rd_data, exp_rd_data);
                errors = errors + 1;
            end
        end
    end

endmodule

// ==== test/eeprom_ctrl_assert.sv ====
`timescale 1ns/1ps

module eeprom_ctrl_assert (
    input logic       CLK,
    input logic       RESET,
    input logic       scl,
    input logic       sda_out,
    input logic       sda_oe,
    input logic       ack,
    input logic       busy,
    input logic [1:0] cur_cmd
);

    logic sda_drv;
    logic in_cond;

    assign sda_drv = sda_oe ? sda_out : 1'b1;   // released reads as high
    assign in_cond = (cur_cmd == eeprom_pkg::CMD_START) || (cur_cmd == eeprom_pkg::CMD_STOP);

    sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !in_cond) |-> $stable(sda_drv))
        else $error("sda moved while scl high outside start or stop");

    ack_one_cycle: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack)
        else $error("ack longer than one cycle");

    idle_after_ack: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !busy)
        else $error("busy high in the cycle after ack");

endmodule

// ==== test/tb_eeprom_ctrl.sv ====
`timescale 1ns/1ps

module tb_eeprom_ctrl;

    localparam int CLK_DIV = 2;
    localparam int SCL_NS  = 4 * CLK_DIV * 20;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wr_data;
    logic [7:0]  rd_data;
    logic        ack;
    logic        nack_err;
    logic        busy;
    logic        scl;
    logic        sda_out;
    logic        sda_oe;
    logic        sda_line;
    logic        model_low;
    logic        force_nack;
    logic        check_rd;
    logic [7:0]  exp_rd_data;
    logic        exp_nack;
    int          chk_errors;
    int          chk_acks;
    int          seq_errors;
    int          n_lines;
    integer      seed;
    logic [3:0]  q_op[$];
    logic [10:0] q_addr[$];
    logic [7:0]  q_data[$];
    logic        q_fn[$];
    logic        q_en[$];

    // open-drain wired-and
    assign sda_line = !((sda_oe && !sda_out) || model_low);

    eeprom_ctrl_top #(.CLK_DIV(CLK_DIV)) dut_i (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wr_data(wr_data),
        .sda_in(sda_line), .rd_data(rd_data), .ack(ack), .nack_err(nack_err),
        .busy(busy), .scl(scl), .sda_out(sda_out), .sda_oe(sda_oe)
    );

    i2c_eeprom_model model_i (
        .CLK(CLK), .RESET(RESET), .scl(scl), .sda(sda_line),
        .force_nack(force_nack), .sda_low(model_low)
    );

    eeprom_ctrl_checker checker_i (
        .CLK(CLK), .RESET(RESET), .ack(ack), .nack_err(nack_err), .rd_data(rd_data),
        .check_rd(check_rd), .exp_rd_data(exp_rd_data), .exp_nack(exp_nack),
        .errors(chk_errors), .acks(chk_acks)
    );

    bind eeprom_ctrl_top eeprom_ctrl_assert assert_i (
        .CLK(CLK), .RESET(RESET), .scl(scl), .sda_out(sda_out), .sda_oe(sda_oe),
        .ack(ack), .busy(busy), .cur_cmd(u_engine.cur_cmd)
    );

    always #10 CLK = ~CLK;

    task automatic load_golden();
        int          fd;
        int          r;
        string       line;
        logic [3:0]  op;
        logic [10:0] a;
        logic [7:0]  d;
        logic        fn;
        logic        en;
        fd = $fopen("test/eeprom_golden.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the golden file");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                r = $fgets(line, fd);
                if (r > 0 && line.len() > 1 && line[0] != "#")
                begin
                    r = $sscanf(line, "%h %h %h %h %h", op, a, d, fn, en);
                    if (r == 5)
                    begin
                        q_op.push_back(op);
                        q_addr.push_back(a);
                        q_data.push_back(d);
                        q_fn.push_back(fn);
                        q_en.push_back(en);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_transaction(input int idx);
        int gap;
        gap         = {$random(seed)} % 6 + 1;
        @(posedge CLK);
        #1;
        check_rd    = q_op[idx][0];
        exp_rd_data = q_data[idx];
        exp_nack    = q_en[idx];
        force_nack  = q_fn[idx];
        wr      = !q_op[idx][0];
        rd      = q_op[idx][0];
        addr    = q_addr[idx];
        wr_data = q_data[idx];
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
        if (!busy)
        begin
            $display("busy did not rise after the strobe for line %0d", idx);
            seq_errors++;
        end
        repeat (3) @(posedge CLK);
        #1;
        rd   = 1'b1;   // must be ignored while busy
        addr = ~q_addr[idx];
        @(posedge CLK);
        #1;
        rd = 1'b0;
        while (!ack)
        begin
            @(posedge CLK);
            #1;
        end
        repeat (gap) @(posedge CLK);
    endtask

    initial
    begin
        CLK         = 1'b0;
        RESET       = 1'b1;
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        wr_data     = '0;
        force_nack  = 1'b0;
        check_rd    = 1'b0;
        exp_rd_data = '0;
        exp_nack    = 1'b0;
        seq_errors  = 0;
        n_lines     = 0;
        seed        = 85744;
        load_golden();
        n_lines = q_op.size();
        if (n_lines == 0)
        begin
            $display("no transactions were read from the golden file");
            seq_errors++;
        end
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;
        for (int i = 0; i < n_lines; i++)
            run_transaction(i);
        repeat (20) @(posedge CLK);
        if (chk_acks != n_lines)
        begin
            $display("saw %0d acks for %0d transactions", chk_acks, n_lines);
            seq_errors++;
        end
        $display("error count %0d (checker %0d, sequence %0d)",
                 chk_errors + seq_errors, chk_errors, seq_errors);
        if (chk_errors + seq_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // watchdog
    initial
    begin
        wait (n_lines != 0);
        #(n_lines * 60 * SCL_NS + 100);
        $display("timeout, transactions did not finish in time");
        $display("error count %0d", chk_errors + seq_errors + 1);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== test/eeprom_golden.txt ====
# columns in hex: op (0 write, 1 read), addr, data, force_nack, expected nack_err
# for reads the data column is the expected byte
0 000 3C 0 0
1 000 3C 0 0
0 7FF 81 0 0
1 7FF 81 0 0
0 123 5A 0 0
0 223 A5 0 0
0 023 11 0 0
1 123 5A 0 0
1 223 A5 0 0
1 023 11 0 0
1 456 FF 0 0
1 6AB FF 0 0
0 123 77 1 1
1 123 5A 0 0
1 000 00 1 1
1 000 3C 0 0
0 3FF C3 0 0
1 3FF C3 0 0
0 400 0F 0 0
1 400 0F 0 0
1 7FF 81 0 0

// ==== sources.f ====
rtl/eeprom_pkg.sv
rtl/i2c_bit_if.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_sequencer.sv
rtl/eeprom_ctrl_top.sv
test/i2c_eeprom_model.sv
test/eeprom_ctrl_checker.sv
test/eeprom_ctrl_assert.sv
test/tb_eeprom_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_eeprom_ctrl \
    -o sim_eeprom

out=$(./obj_dir/sim_eeprom)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi
